// File: hw/proc_c2d_if.sv
`timescale 1ns/1ps
`include "proc_cfg.svh"

interface proc_c2d_if;
	import proc_ctrl_pkg::*;

	pc_sel_e pc_sel;
	ctrl_d_t ctrl_d;
	ctrl_x_t ctrl_x;
	ctrl_w_t ctrl_w;
	logic [`PROC_XLEN-1:0] inst_d; // Instruction held in D.
	logic eq_x; // Operands equal in X.

	modport ctrl (
		output pc_sel,
		output ctrl_d,
		output ctrl_x,
		output ctrl_w,
		input inst_d,
		input eq_x
	);

	modport dpath (
		input pc_sel,
		input ctrl_d,
		input ctrl_x,
		input ctrl_w,
		output inst_d,
		output eq_x
	);
endinterface

// File: hw/proc_cfg.svh
`ifndef PROC_CFG_SVH
`define PROC_CFG_SVH

// Datapath and register file size.
`define PROC_XLEN 32
`define PROC_NREGS 32

`define PROC_RESET_PC 32'h0000_0000 // First fetch address.

// Memory-mapped I/O through CSR numbers.
`define PROC_NUM_IO 3
`define PROC_CSRR_BASE 12'hFC2 // in0 .. in2.
`define PROC_CSRW_BASE 12'h7C2 // out0 .. out2.

`endif

// File: hw/proc_ctrl.sv
`timescale 1ns/1ps
`include "proc_cfg.svh"

module proc_ctrl (
	input logic clk,
	input logic rst,
	proc_c2d_if.ctrl c2d
);
	import proc_isa_pkg::*;
	import proc_ctrl_pkg::*;

	inst_t inst_d;
	inst_t inst_x;
	inst_t inst_m;
	inst_t inst_w;
	logic val_d;
	logic val_x;
	logic val_m;
	logic val_w;
	logic wen_x;
	logic wen_m;
	logic wen_w;
	logic squash_d;
	logic squash_f;
	csr_num_t csrr_num;
	csr_num_t csrw_num;
	pc_sel_e pc_sel;
	ctrl_d_t ctrl_d;
	ctrl_x_t ctrl_x;
	ctrl_w_t ctrl_w;

	function automatic logic is_add(inst_t i);
		return i.opcode == OP && i.funct3 == F3_ADD && i.funct7 == F7_ADD;
	endfunction

	function automatic logic is_addi(inst_t i);
		return i.opcode == OP_IMM && i.funct3 == F3_ADD;
	endfunction

	function automatic logic is_bne(inst_t i);
		return i.opcode == BRANCH && i.funct3 == F3_BNE;
	endfunction

	function automatic logic is_jal(inst_t i);
		return i.opcode == JAL;
	endfunction

	function automatic logic is_csrr(inst_t i);
		return i.opcode == SYSTEM && i.funct3 == F3_CSRRS;
	endfunction

	function automatic logic is_csrw(inst_t i);
		return i.opcode == SYSTEM && i.funct3 == F3_CSRRW;
	endfunction

	function automatic logic writes_rd(inst_t i);
		return is_add(i) || is_addi(i) || is_jal(i) || is_csrr(i);
	endfunction

	function automatic logic hit(logic wen, reg_addr_t rd, reg_addr_t rs);
		return wen && rd != '0 && rd == rs;
	endfunction

	// Nearest producer wins.
	function automatic byp_sel_e pick_byp(logic hit_x, logic hit_m, logic hit_w);
		if (hit_x)
			return BYP_X;
		if (hit_m)
			return BYP_M;
		if (hit_w)
			return BYP_W;
		return BYP_RF;
	endfunction

	assign inst_d = c2d.inst_d;
	assign csrr_num = inst_d[31:20];
	assign csrw_num = inst_w[31:20];

	always_ff @(posedge clk) begin
		if (rst) begin
			val_d <= 1'b0;
			val_x <= 1'b0;
			val_m <= 1'b0;
			val_w <= 1'b0;
		end else begin
			val_d <= !squash_f;
			val_x <= val_d && !squash_d;
			val_m <= val_x;
			val_w <= val_m;
		end
	end

	always_ff @(posedge clk) begin
		inst_x <= inst_d;
		inst_m <= inst_x;
		inst_w <= inst_m;
	end

	assign wen_x = val_x && writes_rd(inst_x);
	assign wen_m = val_m && writes_rd(inst_m);
	assign wen_w = val_w && writes_rd(inst_w);

	assign squash_d = val_x && is_bne(inst_x) && !c2d.eq_x; // Taken bne.
	assign squash_f = squash_d || (val_d && is_jal(inst_d));

	always_comb begin
		if (squash_d)
			pc_sel = PC_BTARG;
		else if (val_d && is_jal(inst_d))
			pc_sel = PC_JTARG;
		else
			pc_sel = PC_PLUS4;
	end

	always_comb begin
		ctrl_d = '0;
		if (val_d) begin
			ctrl_d.op1_byp = pick_byp(hit(wen_x, inst_x.rd, inst_d.rs1),
				hit(wen_m, inst_m.rd, inst_d.rs1), hit(wen_w, inst_w.rd, inst_d.rs1));
			ctrl_d.op2_byp = pick_byp(hit(wen_x, inst_x.rd, inst_d.rs2),
				hit(wen_m, inst_m.rd, inst_d.rs2), hit(wen_w, inst_w.rd, inst_d.rs2));
			if (is_addi(inst_d)) begin
				ctrl_d.imm_type = IMM_I;
				ctrl_d.op2_sel = OP2_IMM;
			end
			if (is_bne(inst_d))
				ctrl_d.imm_type = IMM_B; // Target resolved later in X.
			if (is_jal(inst_d)) begin
				ctrl_d.imm_type = IMM_J;
				ctrl_d.op1_sel = OP1_PC; // Link value pc + 4.
				ctrl_d.op2_sel = OP2_FOUR;
			end
			if (is_csrr(inst_d) && csrr_num >= `PROC_CSRR_BASE
				&& csrr_num < `PROC_CSRR_BASE + `PROC_NUM_IO)
				ctrl_d.csrr_idx = io_idx_t'(csrr_num - `PROC_CSRR_BASE);
		end
	end

	always_comb begin
		ctrl_x = '0;
		if (val_x && is_bne(inst_x))
			ctrl_x.alu_fn = ALU_EQ;
		if (val_x && is_csrr(inst_x))
			ctrl_x.result_sel = RES_CSRR;
	end

	always_comb begin
		ctrl_w = '0;
		if (val_w) begin
			ctrl_w.rf_wen = wen_w; // x0 writes dropped in the regfile.
			ctrl_w.rf_waddr = inst_w.rd;
			if (is_csrw(inst_w) && csrw_num >= `PROC_CSRW_BASE
				&& csrw_num < `PROC_CSRW_BASE + `PROC_NUM_IO)
				ctrl_w.csrw_en[io_idx_t'(csrw_num - `PROC_CSRW_BASE)] = 1'b1;
		end
	end

	assign c2d.pc_sel = pc_sel;
	assign c2d.ctrl_d = ctrl_d;
	assign c2d.ctrl_x = ctrl_x;
	assign c2d.ctrl_w = ctrl_w;

	// A csrw never writes the register file.
	a_csrw_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({ctrl_w.csrw_en, ctrl_w.rf_wen}));

	// A taken branch empties D and X, so a jal behind it dies.
	a_squash_kills: assert property (@(posedge clk) disable iff (rst)
		squash_d |=> !val_d && !val_x);
endmodule

// File: hw/proc_ctrl_pkg.sv
`include "proc_cfg.svh"

package proc_ctrl_pkg;

	localparam int IO_IDX_W = $clog2(`PROC_NUM_IO);
	typedef logic [IO_IDX_W-1:0] io_idx_t;

	typedef enum logic [1:0] {PC_PLUS4, PC_JTARG, PC_BTARG} pc_sel_e;
	typedef enum logic [1:0] {BYP_RF, BYP_X, BYP_M, BYP_W} byp_sel_e;
	typedef enum logic {OP1_RS1, OP1_PC} op1_sel_e;
	typedef enum logic [1:0] {OP2_RS2, OP2_IMM, OP2_FOUR} op2_sel_e;
	typedef enum logic {RES_ALU, RES_CSRR} result_sel_e;
	typedef enum logic {ALU_ADD, ALU_EQ} alu_fn_e;

	typedef struct packed {
		proc_isa_pkg::imm_type_e imm_type;
		byp_sel_e op1_byp;
		byp_sel_e op2_byp;
		op1_sel_e op1_sel;
		op2_sel_e op2_sel;
		io_idx_t csrr_idx;
	} ctrl_d_t;

	typedef struct packed {
		alu_fn_e alu_fn;
		result_sel_e result_sel;
	} ctrl_x_t;

	typedef struct packed {
		logic rf_wen;
		proc_isa_pkg::reg_addr_t rf_waddr;
		logic [`PROC_NUM_IO-1:0] csrw_en; // One-hot over out0 .. out2.
	} ctrl_w_t;

endpackage

// File: hw/proc_dpath.sv
`timescale 1ns/1ps
`include "proc_cfg.svh"

module proc_dpath (
	input logic clk,
	input logic rst,
	proc_c2d_if.dpath c2d,
	output proc_isa_pkg::word_t imemreq_addr,
	input proc_isa_pkg::word_t imemresp_data,
	input proc_isa_pkg::word_t in0,
	input proc_isa_pkg::word_t in1,
	input proc_isa_pkg::word_t in2,
	output proc_isa_pkg::word_t out0,
	output proc_isa_pkg::word_t out1,
	output proc_isa_pkg::word_t out2,
	output logic rf_wen,
	output proc_isa_pkg::reg_addr_t rf_waddr,
	output proc_isa_pkg::word_t rf_wdata,
	output proc_isa_pkg::reg_addr_t rf_raddr0,
	output proc_isa_pkg::reg_addr_t rf_raddr1,
	input proc_isa_pkg::word_t rf_rdata0,
	input proc_isa_pkg::word_t rf_rdata1
);
	import proc_isa_pkg::*;
	import proc_ctrl_pkg::*;

	word_t pc_f;
	word_t pc_next_f;
	inst_t inst_d;
	word_t pc_d;
	word_t imm_d;
	word_t targ_d;
	word_t op1_byp_d;
	word_t op2_byp_d;
	word_t op1_d;
	word_t op2_d;
	word_t btarg_x;
	word_t op1_x;
	word_t op2_x;
	word_t csrr_x;
	word_t csrw_x;
	word_t alu_x;
	word_t result_x;
	word_t result_m;
	word_t csrw_m;
	word_t result_w;
	word_t csrw_w;
	word_t in_port [`PROC_NUM_IO];
	word_t out_reg [`PROC_NUM_IO];

	function automatic word_t byp_mux(byp_sel_e sel, word_t rf, word_t x, word_t m, word_t w);
		case (sel)
			BYP_X: return x;
			BYP_M: return m;
			BYP_W: return w;
			default: return rf;
		endcase
	endfunction

	always_comb begin
		case (c2d.pc_sel)
			PC_JTARG: pc_next_f = targ_d;
			PC_BTARG: pc_next_f = btarg_x;
			default: pc_next_f = pc_f + 32'd4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_f <= `PROC_RESET_PC;
		end else begin
			pc_f <= pc_next_f;
		end
	end

	assign imemreq_addr = pc_f;

	always_ff @(posedge clk) begin
		inst_d <= imemresp_data;
		pc_d <= pc_f;
	end

	assign c2d.inst_d = inst_d;
	assign rf_raddr0 = inst_d.rs1;
	assign rf_raddr1 = inst_d.rs2;

	always_comb begin
		case (c2d.ctrl_d.imm_type)
			IMM_B: imm_d = {{20{inst_d[31]}}, inst_d[7], inst_d[30:25], inst_d[11:8], 1'b0};
			IMM_J: imm_d = {{12{inst_d[31]}}, inst_d[19:12], inst_d[20], inst_d[30:21], 1'b0};
			default: imm_d = {{20{inst_d[31]}}, inst_d[31:20]};
		endcase
	end

	assign targ_d = pc_d + imm_d; // Shared by jal and bne.

	assign op1_byp_d = byp_mux(c2d.ctrl_d.op1_byp, rf_rdata0, result_x, result_m, result_w);
	assign op2_byp_d = byp_mux(c2d.ctrl_d.op2_byp, rf_rdata1, result_x, result_m, result_w);
	assign op1_d = (c2d.ctrl_d.op1_sel == OP1_PC) ? pc_d : op1_byp_d;

	always_comb begin
		case (c2d.ctrl_d.op2_sel)
			OP2_IMM: op2_d = imm_d;
			OP2_FOUR: op2_d = 32'd4;
			default: op2_d = op2_byp_d;
		endcase
	end

	assign in_port[0] = in0;
	assign in_port[1] = in1;
	assign in_port[2] = in2;

	always_ff @(posedge clk) begin
		op1_x <= op1_d;
		op2_x <= op2_d;
		btarg_x <= targ_d;
		csrr_x <= in_port[c2d.ctrl_d.csrr_idx]; // Sampled in D.
		csrw_x <= op1_byp_d;
	end

	assign alu_x = (c2d.ctrl_x.alu_fn == ALU_EQ) ? word_t'(op1_x == op2_x) : op1_x + op2_x;
	assign c2d.eq_x = alu_x[0];
	assign result_x = (c2d.ctrl_x.result_sel == RES_CSRR) ? csrr_x : alu_x;

	always_ff @(posedge clk) begin
		result_m <= result_x;
		csrw_m <= csrw_x;
		result_w <= result_m;
		csrw_w <= csrw_m;
	end

	assign rf_wen = c2d.ctrl_w.rf_wen;
	assign rf_waddr = c2d.ctrl_w.rf_waddr;
	assign rf_wdata = result_w;

	always_ff @(posedge clk) begin
		for (int i = 0; i < `PROC_NUM_IO; i++) begin
			if (rst) begin
				out_reg[i] <= '0;
			end else if (c2d.ctrl_w.csrw_en[i]) begin
				out_reg[i] <= csrw_w;
			end
		end
	end

	assign out0 = out_reg[0];
	assign out1 = out_reg[1];
	assign out2 = out_reg[2];

	a_sel_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown({c2d.pc_sel, c2d.ctrl_d, c2d.ctrl_x, c2d.ctrl_w}));
endmodule

// File: hw/proc_isa_pkg.sv
`include "proc_cfg.svh"

package proc_isa_pkg;

	typedef logic [`PROC_XLEN-1:0] word_t;
	typedef logic [$clog2(`PROC_NREGS)-1:0] reg_addr_t;
	typedef logic [11:0] csr_num_t;

	// Only the major opcodes of the supported subset.
	typedef enum logic [6:0] {
		OP = 7'b0110011,
		OP_IMM = 7'b0010011,
		BRANCH = 7'b1100011,
		JAL = 7'b1101111,
		SYSTEM = 7'b1110011
	} opcode_e;

	localparam logic [2:0] F3_ADD = 3'b000; // add and addi.
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_CSRRW = 3'b001; // csrw is csrrw x0.
	localparam logic [2:0] F3_CSRRS = 3'b010; // csrr is csrrs with rs1 x0.
	localparam logic [6:0] F7_ADD = 7'b0000000;

	typedef enum logic [1:0] {
		IMM_I = 2'd0,
		IMM_B = 2'd1,
		IMM_J = 2'd2
	} imm_type_e;

	// R-type field layout; other formats reuse the same bits.
	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t rs2;
		reg_addr_t rs1;
		logic [2:0] funct3;
		reg_addr_t rd;
		opcode_e opcode;
	} inst_t;

endpackage

// File: hw/proc_regfile.sv
`timescale 1ns/1ps
`include "proc_cfg.svh"

module proc_regfile (
	input logic clk,
	input logic wen,
	input proc_isa_pkg::reg_addr_t waddr,
	input proc_isa_pkg::word_t wdata,
	input proc_isa_pkg::reg_addr_t raddr0,
	input proc_isa_pkg::reg_addr_t raddr1,
	output proc_isa_pkg::word_t rdata0,
	output proc_isa_pkg::word_t rdata1
);
	import proc_isa_pkg::*;

	word_t regs [`PROC_NREGS];

	always_ff @(posedge clk) begin
		if (wen && waddr != '0)
			regs[waddr] <= wdata;
	end

	// x0 reads as zero.
	assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
endmodule

// File: hw/proc_top.sv
`timescale 1ns/1ps
`include "proc_cfg.svh"

module proc_top (
	input logic clk,
	input logic rst,
	output proc_isa_pkg::word_t imemreq_addr,
	input proc_isa_pkg::word_t imemresp_data,
	input proc_isa_pkg::word_t in0,
	input proc_isa_pkg::word_t in1,
	input proc_isa_pkg::word_t in2,
	output proc_isa_pkg::word_t out0,
	output proc_isa_pkg::word_t out1,
	output proc_isa_pkg::word_t out2
);
	import proc_isa_pkg::*;

	logic rf_wen;
	reg_addr_t rf_waddr;
	word_t rf_wdata;
	reg_addr_t rf_raddr0;
	reg_addr_t rf_raddr1;
	word_t rf_rdata0;
	word_t rf_rdata1;

	proc_c2d_if c2d ();

	proc_ctrl i_ctrl (
		.clk(clk),
		.rst(rst),
		.c2d(c2d.ctrl)
	);

	proc_dpath i_dpath (
		.clk(clk),
		.rst(rst),
		.c2d(c2d.dpath),
		.imemreq_addr(imemreq_addr),
		.imemresp_data(imemresp_data),
		.in0(in0),
		.in1(in1),
		.in2(in2),
		.out0(out0),
		.out1(out1),
		.out2(out2),
		.rf_wen(rf_wen),
		.rf_waddr(rf_waddr),
		.rf_wdata(rf_wdata),
		.rf_raddr0(rf_raddr0),
		.rf_raddr1(rf_raddr1),
		.rf_rdata0(rf_rdata0),
		.rf_rdata1(rf_rdata1)
	);

	proc_regfile i_regfile (
		.clk(clk),
		.wen(rf_wen),
		.waddr(rf_waddr),
		.wdata(rf_wdata),
		.raddr0(rf_raddr0),
		.raddr1(rf_raddr1),
		.rdata0(rf_rdata0),
		.rdata1(rf_rdata1)
	);
endmodule

// File: testbench/proc_tb.sv
`timescale 1ns/1ps
`include "proc_cfg.svh"

module proc_tb;
	import proc_isa_pkg::*;

	localparam int IMEM_WORDS = 256;
	localparam int HALT_TIMEOUT = 2000;
	localparam int ISS_MAX_STEPS = 1000;

	logic clk;
	logic rst;
	word_t imemreq_addr;
	word_t imemresp_data;
	word_t in0;
	word_t in1;
	word_t in2;
	word_t out0;
	word_t out1;
	word_t out2;

	word_t imem [IMEM_WORDS];
	word_t in_val [`PROC_NUM_IO];
	word_t last_out [`PROC_NUM_IO];
	word_t cur_out [`PROC_NUM_IO];
	word_t exp_q [`PROC_NUM_IO][$];
	word_t exp_val;
	word_t halt_addr;
	int n_words;
	int seed;
	int mismatch_cnt;
	int fail_cnt;
	int cyc;
	logic watch;

	proc_top i_dut (
		.clk(clk),
		.rst(rst),
		.imemreq_addr(imemreq_addr),
		.imemresp_data(imemresp_data),
		.in0(in0),
		.in1(in1),
		.in2(in2),
		.out0(out0),
		.out1(out1),
		.out2(out2)
	);

	assign imemresp_data = imem[imemreq_addr[9:2]]; // Same-cycle fetch.

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic word_t add_inst(int rd, int rs1, int rs2);
		return {7'b0000000, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'b0110011};
	endfunction

	function automatic word_t addi_inst(int rd, int rs1, int imm);
		return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
	endfunction

	function automatic word_t bne_inst(int rs1, int rs2, int off);
		logic [12:0] b;
		b = 13'(off);
		return {b[12], b[10:5], 5'(rs2), 5'(rs1), 3'b001, b[4:1], b[11], 7'b1100011};
	endfunction

	function automatic word_t jal_inst(int rd, int off);
		logic [20:0] j;
		j = 21'(off);
		return {j[20], j[10:1], j[11], j[19:12], 5'(rd), 7'b1101111};
	endfunction

	function automatic word_t csrr_inst(int rd, int idx);
		return {12'(`PROC_CSRR_BASE + idx), 5'd0, 3'b010, 5'(rd), 7'b1110011};
	endfunction

	function automatic word_t csrw_inst(int idx, int rs1);
		return {12'(`PROC_CSRW_BASE + idx), 5'(rs1), 3'b001, 5'd0, 7'b1110011};
	endfunction

	task automatic emit(word_t w);
		imem[n_words] = w;
		n_words++;
	endtask

	task automatic build_program();
		n_words = 0;
		emit(addi_inst(1, 0, 5));
		emit(addi_inst(2, 1, 7)); // Distance 1.
		emit(add_inst(3, 2, 1));
		emit(addi_inst(4, 0, 100));
		emit(add_inst(5, 3, 2)); // Distances 2 and 3.
		emit(add_inst(6, 5, 4));
		emit(addi_inst(0, 6, 55)); // Must not reach x0.
		emit(add_inst(7, 0, 6));
		emit(csrw_inst(0, 7));
		emit(add_inst(8, 7, 5));
		emit(csrw_inst(0, 8));
		emit(addi_inst(10, 0, 5)); // Loop count.
		emit(addi_inst(11, 0, 0));
		emit(add_inst(11, 11, 10));
		emit(addi_inst(10, 10, -1));
		emit(bne_inst(10, 0, -8));
		emit(csrw_inst(2, 11)); // Wrong path while looping.
		emit(bne_inst(11, 0, 12));
		emit(csrw_inst(2, 10)); // Always skipped.
		emit(csrw_inst(2, 1));
		emit(jal_inst(12, 8));
		emit(csrw_inst(1, 1));
		emit(csrw_inst(1, 12)); // Link value.
		emit(csrr_inst(13, 0));
		emit(csrr_inst(14, 1));
		emit(csrr_inst(15, 2));
		emit(add_inst(16, 13, 14));
		emit(add_inst(17, 14, 15));
		emit(add_inst(18, 15, 13));
		emit(csrw_inst(0, 16));
		emit(csrw_inst(1, 17));
		emit(csrw_inst(2, 18));
		halt_addr = `PROC_RESET_PC + word_t'(n_words * 4);
		emit(jal_inst(0, 0));
	endtask

	// Runs the program in order and queues each visible change of an out port.
	function automatic void iss_run();
		word_t x [`PROC_NREGS];
		word_t outs [`PROC_NUM_IO];
		word_t pc;
		word_t npc;
		word_t i;
		word_t a;
		word_t b;
		word_t res;
		int idx;
		logic wr;
		logic halted;
		halted = 1'b0;
		pc = `PROC_RESET_PC;
		for (int r = 0; r < `PROC_NREGS; r++)
			x[r] = '0;
		for (int k = 0; k < `PROC_NUM_IO; k++)
			outs[k] = '0;
		for (int step = 0; step < ISS_MAX_STEPS && !halted; step++) begin
			i = imem[pc[9:2]];
			a = x[i[19:15]];
			b = x[i[24:20]];
			npc = pc + 4;
			wr = 1'b0;
			res = '0;
			if (i == jal_inst(0, 0)) begin
				halted = 1'b1;
			end else begin
				case (i[6:0])
					OP: begin
						res = a + b;
						wr = 1'b1;
					end
					OP_IMM: begin
						res = a + {{20{i[31]}}, i[31:20]};
						wr = 1'b1;
					end
					BRANCH: begin
						if (a != b)
							npc = pc + {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
					end
					JAL: begin
						res = pc + 4;
						wr = 1'b1;
						npc = pc + {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
					end
					SYSTEM: begin
						if (i[14:12] == 3'b010) begin
							idx = int'(i[31:20]) - int'(`PROC_CSRR_BASE);
							res = in_val[idx];
							wr = 1'b1;
						end else begin
							idx = int'(i[31:20]) - int'(`PROC_CSRW_BASE);
							if (a !== outs[idx])
								exp_q[idx].push_back(a);
							outs[idx] = a;
						end
					end
					default: ; // Fill words are nops.
				endcase
				if (wr && i[11:7] != 5'd0)
					x[i[11:7]] = res;
				pc = npc;
			end
		end
		if (!halted) begin
			$display("Reference model never reached the halt loop");
			fail_cnt++;
		end
	endfunction

	task automatic expect_word(string name, word_t act, word_t exp);
		if (act !== exp) begin
			$display("Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
			mismatch_cnt++;
		end
	endtask

	task automatic verify_reset_state();
		expect_word("imemreq_addr", imemreq_addr, `PROC_RESET_PC);
		expect_word("out0", out0, '0);
		expect_word("out1", out1, '0);
		expect_word("out2", out2, '0);
	endtask

	always @(posedge clk) begin
		if (watch) begin
			cur_out[0] = out0;
			cur_out[1] = out1;
			cur_out[2] = out2;
			for (int k = 0; k < `PROC_NUM_IO; k++) begin
				if (cur_out[k] !== last_out[k]) begin
					if (exp_q[k].size() == 0) begin
						$display("out%0d changed to %h at %0t with no write left to expect",
							k, cur_out[k], $time);
						fail_cnt++;
					end else begin
						exp_val = exp_q[k].pop_front();
						if (cur_out[k] !== exp_val) begin
							$display("Error at %0t: out%0d expected %h, actual %h",
								$time, k, exp_val, cur_out[k]);
							mismatch_cnt++;
						end
					end
					last_out[k] = cur_out[k];
				end
			end
		end
	end

	initial begin
		rst = 1'b1;
		in0 = '0;
		in1 = '0;
		in2 = '0;
		watch = 1'b0;
		mismatch_cnt = 0;
		fail_cnt = 0;
		seed = 32'hbe48;
		for (int k = 0; k < IMEM_WORDS; k++)
			imem[k] = addi_inst(0, 0, k); // Nop tagged with its own index.
		build_program();
		for (int k = 0; k < `PROC_NUM_IO; k++)
			in_val[k] = $random(seed);
		iss_run();
		for (int c = 0; c < 10; c++) begin
			@(negedge clk);
			if (c == 0) begin
				in0 = in_val[0];
				in1 = in_val[1];
				in2 = in_val[2];
			end
			verify_reset_state();
		end
		rst = 1'b0;
		verify_reset_state(); // PC still at reset until the next edge.
		for (int k = 0; k < `PROC_NUM_IO; k++)
			last_out[k] = '0;
		watch = 1'b1;
		cyc = 0;
		while (imemreq_addr !== halt_addr && cyc < HALT_TIMEOUT) begin
			@(negedge clk);
			cyc++;
		end
		if (imemreq_addr === halt_addr) begin
			repeat (8) @(negedge clk); // Drain the pipeline.
			for (int k = 0; k < `PROC_NUM_IO; k++) begin
				if (exp_q[k].size() != 0) begin
					$display("out%0d is missing %0d expected writes", k, exp_q[k].size());
					fail_cnt++;
				end
			end
		end else begin
			$display("Timed out after %0d cycles waiting for the fetch of the halt loop", cyc);
			fail_cnt++;
		end
		$display("Errors: %0d value mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if (mismatch_cnt + fail_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end
endmodule

// File: vlog.f
+incdir+hw
hw/proc_isa_pkg.sv
hw/proc_ctrl_pkg.sv
hw/proc_c2d_if.sv
hw/proc_regfile.sv
hw/proc_ctrl.sv
hw/proc_dpath.sv
hw/proc_top.sv
testbench/proc_tb.sv
